/* bench/tb_dram_fifo.sv */
// ------------------------------
// dram fifo testbench
// random streams against a queue model, readback and calibration checks
// ------------------------------
`include "dram_fifo_cfg.svh"

module tb_dram_fifo;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LEN_CALIB  = `DF_DEPTH + 40;           // cycles per test, rough upper bounds
    localparam int LEN_STREAM = 2000 * 4;
    localparam int LEN_FILL   = `DF_DEPTH * 4 + 40;
    localparam int LEN_MASK   = 500 * 4;
    localparam int LEN_RB     = 400;
    localparam int WDOG_CYCLES = 4 * (LEN_CALIB + LEN_STREAM + LEN_FILL + LEN_MASK + LEN_RB);

    logic                    ddr3_axi_clk;
    logic                    i_reset;
    dram_fifo_pkg::df_data_t i_tdata;
    logic                    i_tlast;
    logic                    i_tvalid;
    logic                    o_tready;
    dram_fifo_pkg::df_data_t o_tdata;
    logic                    o_tlast;
    logic                    o_tvalid;
    logic                    i_tready;
    logic                    i_set_stb;
    logic [7:0]              i_set_addr;
    logic [31:0]             i_set_data;
    logic [31:0]             o_rb_data;
    dram_fifo_pkg::df_data_t i_forced_bit_err;
    logic                    o_init_calib_complete;

    dram_fifo_pkg::df_word_t model_q [$];                 // words expected at the output
    logic [31:0]             rng_state;
    logic                    in_took;                     // input transfer in last cycle
    int                      words_in;
    int                      pkts_in;                     // last words sent into the DUT
    int                      pkts_out;                    // last words taken from the model
    int                      errors;
    int                      tests_ok;
    int                      tests_bad;

    dram_fifo_top i_dut (
        .ddr3_axi_clk          (ddr3_axi_clk),
        .i_reset               (i_reset),
        .i_tdata               (i_tdata),
        .i_tlast               (i_tlast),
        .i_tvalid              (i_tvalid),
        .o_tready              (o_tready),
        .o_tdata               (o_tdata),
        .o_tlast               (o_tlast),
        .o_tvalid              (o_tvalid),
        .i_tready              (i_tready),
        .i_set_stb             (i_set_stb),
        .i_set_addr            (i_set_addr),
        .i_set_data            (i_set_data),
        .o_rb_data             (o_rb_data),
        .i_forced_bit_err      (i_forced_bit_err),
        .o_init_calib_complete (o_init_calib_complete)
    );

    always #4 ddr3_axi_clk = ~ddr3_axi_clk;               // 8 ns period

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13);        // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_word(input string name, input dram_fifo_pkg::df_word_t got,
                              input dram_fifo_pkg::df_word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rb(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // sample at the falling edge, then return 1 ns after the next rising edge
    task automatic tick();
        dram_fifo_pkg::df_word_t got;
        dram_fifo_pkg::df_word_t exp;
        @(negedge ddr3_axi_clk);
        in_took = i_tvalid & o_tready;
        if (in_took) begin
            exp.data = i_tdata ^ i_forced_bit_err;        // mask taken at acceptance
            exp.last = i_tlast;
            model_q.push_back(exp);
            words_in++;
            if (i_tlast) pkts_in++;
        end
        if (o_tvalid && i_tready) begin
            got.data = o_tdata;
            got.last = o_tlast;
            if (model_q.size() == 0) begin
                $display("output word %h came out while the model expected nothing", got);
                errors++;
            end else begin
                exp = model_q.pop_front();
                check_word("o_tlast/o_tdata", got, exp);
                if (exp.last) pkts_out++;
            end
        end
        @(posedge ddr3_axi_clk);
        #1;
    endtask

    // new word only once the previous one has gone
    task automatic drive_word(input logic want);
        logic [31:0] r;
        if (!i_tvalid || in_took) begin
            r = rand32();
            i_tvalid = want;
            i_tdata  = {rand32(), rand32()};
            i_tlast  = (r[2:0] == 3'd0);                  // about one in eight
        end
    endtask

    task automatic random_traffic(input int n_words);
        int          start;
        logic [31:0] r;
        start = words_in;
        while (words_in - start < n_words) begin
            r = rand32();
            drive_word(r[0] | r[1]);
            i_tready = r[2] | r[3];
            tick();
        end
        i_tvalid = 1'b0;
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        i_tvalid = 1'b0;
        i_tready = 1'b1;
        while (model_q.size() != 0 && n < limit) begin
            tick();
            n++;
        end
        if (model_q.size() != 0) begin
            $display("output stalled with %0d words still expected", model_q.size());
            errors++;
        end
        repeat (4) tick();                                 // catches stray extra words
    endtask

    task automatic set_select(input dram_fifo_pkg::df_rb_sel_t sel);
        i_set_stb  = 1'b1;
        i_set_addr = `DF_SR_BASE;
        i_set_data = 32'(sel);
        tick();
        i_set_stb  = 1'b0;
        i_set_data = 32'd0;
        tick();                                            // readback register catches up
        tick();
    endtask

    task automatic end_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("%s ok", name);
            tests_ok++;
        end else begin
            $display("%s %0d errors", name, errors - start_errors);
            tests_bad++;
        end
    endtask

    // ------------------------------
    // watchdog
    // ------------------------------
    initial begin
        repeat (WDOG_CYCLES) @(posedge ddr3_axi_clk);
        $display("timeout: run did not finish within %0d cycles", WDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        int start;
        int n;
        int base;
        dram_fifo_pkg::df_data_t mask;
        ddr3_axi_clk = 1'b0;
        i_reset = 1'b1;
        i_tdata = '0;
        i_tlast = 1'b0;
        i_tvalid = 1'b0;
        i_tready = 1'b0;
        i_set_stb = 1'b0;
        i_set_addr = 8'd0;
        i_set_data = 32'd0;
        i_forced_bit_err = '0;
        rng_state = 32'h38faba79;
        in_took = 1'b0;
        words_in = 0;
        pkts_in = 0;
        pkts_out = 0;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        repeat (8) @(posedge ddr3_axi_clk);
        #1;
        i_reset = 1'b0;

        // calibration, nothing may enter during the clear sweep
        start = errors;
        check_flag("o_init_calib_complete", o_init_calib_complete, 1'b0);
        check_flag("o_tready", o_tready, 1'b0);
        check_flag("o_tvalid", o_tvalid, 1'b0);
        drive_word(1'b1);
        n = 0;
        while (!o_init_calib_complete && n <= `DF_DEPTH + 1) begin
            check_flag("o_tready", o_tready, 1'b0);
            tick();
            n++;
        end
        if (!o_init_calib_complete || n != `DF_DEPTH + 1) begin
            $display("calibration did not complete exactly %0d cycles after reset",
                     `DF_DEPTH + 1);
            errors++;
        end
        i_tvalid = 1'b0;
        end_test("calibration", start);

        start = errors;
        random_traffic(2000);
        drain(LEN_STREAM);
        end_test("random stream", start);

        // fill with output stalled
        start = errors;
        i_tready = 1'b0;
        for (int i = 0; i < `DF_DEPTH; i++) begin
            check_flag("o_tready", o_tready, 1'b1);
            drive_word(1'b1);
            tick();
        end
        for (int i = 0; i < 4; i++) begin
            check_flag("o_tready", o_tready, 1'b0);       // full, extra word must wait
            drive_word(1'b1);
            tick();
        end
        drain(LEN_FILL);
        end_test("fill and drain", start);

        start = errors;
        mask = {rand32(), rand32()};
        if (mask == '0) mask = 64'd1;
        i_forced_bit_err = mask;
        random_traffic(500);
        drain(LEN_MASK);
        i_forced_bit_err = '0;
        end_test("bit error mask", start);

        // readback with words parked in the fifo
        start = errors;
        i_tready = 1'b0;
        n = 16 + int'(rand32() & 32'h1f);
        base = words_in;
        while (words_in - base < n) begin
            drive_word(1'b1);
            if (words_in - base == n - 1) begin
                i_tlast = 1'b1;                            // parked packet count differs
            end
            tick();
        end
        i_tvalid = 1'b0;
        repeat (4) tick();
        set_select(dram_fifo_pkg::RB_PKTS_IN);
        check_rb("o_rb_data", o_rb_data, 32'(pkts_in));
        set_select(dram_fifo_pkg::RB_PKTS_OUT);
        check_rb("o_rb_data", o_rb_data, 32'(pkts_out));
        set_select(dram_fifo_pkg::RB_LEVEL);
        check_rb("o_rb_data", o_rb_data, 32'(model_q.size()));
        drain(LEN_RB);
        end_test("readback", start);

        $display("summary: %0d tests ok, %0d tests with errors, %0d failed checks",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* logic/dram_fifo_cfg.svh */
// ------------------------------
// dram fifo size constants
// depth, widths and settings bus address map
// ------------------------------
`ifndef DRAM_FIFO_CFG_SVH
`define DRAM_FIFO_CFG_SVH

`define DF_DEPTH    256     // memory words
`define DF_ADDR_W   8       // log2 of depth
`define DF_DATA_W   64      // stream data width

// ------------------------------
// settings bus map
// ------------------------------
`define DF_SR_BASE  8'h00   // readback select register

`endif

/* logic/dram_fifo_egress.sv */
// ------------------------------
// fifo output stage
// issues memory reads and holds a two word output buffer
// ------------------------------
`include "dram_fifo_cfg.svh"

module dram_fifo_egress (
    input  logic                      ddr3_axi_clk,
    input  logic                      i_reset,
    mem_wr_if.mon                     wr_mon,
    mem_rd_if.rd                      rd,
    output dram_fifo_pkg::df_ptr_t    o_rd_ptr,      // words handed out of the fifo
    output dram_fifo_pkg::df_data_t   o_tdata,
    output logic                      o_tlast,
    output logic                      o_tvalid,
    input  logic                      i_tready,
    output dram_fifo_pkg::df_level_t  o_level,
    output logic                      o_pkt_out_stb
);

    dram_fifo_pkg::df_ptr_t   rd_ptr_q;              // next address to read
    logic [1:0]               credits_q;             // free buffer slots, minus in flight
    logic [1:0]               held;                  // read but not yet taken
    logic [1:0]               buf_cnt_q;
    logic                     wr_idx_q;
    logic                     rd_idx_q;
    dram_fifo_pkg::df_word_t  buf_q [2];
    logic                     empty;
    logic                     pop;
    logic                     issue;

    assign empty = (wr_mon.wr_ptr == rd_ptr_q);
    assign pop   = o_tvalid & i_tready;
    assign issue = ~empty & ((credits_q != 2'd0) | pop);   // slot freed this cycle counts

    assign rd.rd_stb  = issue;
    assign rd.rd_addr = rd_ptr_q[`DF_ADDR_W-1:0];

    // ------------------------------
    // pointers and credits
    // ------------------------------
    always_ff @(posedge ddr3_axi_clk) begin
        if (i_reset) begin
            rd_ptr_q  <= '0;
            credits_q <= 2'd2;
            buf_cnt_q <= 2'd0;
            wr_idx_q  <= 1'b0;
            rd_idx_q  <= 1'b0;
        end else begin
            if (issue) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            credits_q <= credits_q - {1'b0, issue} + {1'b0, pop};
            buf_cnt_q <= buf_cnt_q + {1'b0, rd.rd_valid} - {1'b0, pop};
            if (rd.rd_valid) begin
                wr_idx_q <= ~wr_idx_q;               // catch side of the ring
            end
            if (pop) begin
                rd_idx_q <= ~rd_idx_q;
            end
        end
    end

    // buffer payload, credits keep it from overrunning
    always_ff @(posedge ddr3_axi_clk) begin
        if (rd.rd_valid) begin
            buf_q[wr_idx_q] <= rd.rd_data;
        end
    end

    // ------------------------------
    // output stream and status
    // ------------------------------
    assign o_tvalid = (buf_cnt_q != 2'd0);
    assign o_tdata  = buf_q[rd_idx_q].data;          // head holds until taken
    assign o_tlast  = buf_q[rd_idx_q].last;

    assign o_pkt_out_stb = pop & o_tlast;

    // words in flight or buffered still occupy fifo space
    assign held     = 2'd2 - credits_q;
    assign o_rd_ptr = rd_ptr_q - {{(`DF_ADDR_W-1){1'b0}}, held};
    assign o_level  = wr_mon.wr_ptr - o_rd_ptr;

endmodule

/* logic/dram_fifo_if.sv */
// ------------------------------
// memory write and read ports
// single cycle strobes, memory never stalls
// ------------------------------
`include "dram_fifo_cfg.svh"

interface mem_wr_if #(
    parameter type payload_t = logic
);
    logic                 wr_stb;      // write this cycle
    logic [`DF_ADDR_W-1:0] wr_addr;
    payload_t             wr_data;
    logic [`DF_ADDR_W:0]   wr_ptr;      // committed write pointer

    modport wr (
        output wr_stb, wr_addr, wr_data, wr_ptr
    );

    modport sink (
        input  wr_stb, wr_addr, wr_data
    );

    // read side only watches the pointer for empty
    modport mon (
        input  wr_ptr
    );
endinterface

interface mem_rd_if #(
    parameter type payload_t = logic
);
    logic                 rd_stb;      // issue read this cycle
    logic [`DF_ADDR_W-1:0] rd_addr;
    logic                 rd_valid;    // one cycle after rd_stb
    payload_t             rd_data;

    modport rd (
        output rd_stb, rd_addr,
        input  rd_valid, rd_data
    );

    modport src (
        input  rd_stb, rd_addr,
        output rd_valid, rd_data
    );
endinterface

/* logic/dram_fifo_ingress.sv */
// ------------------------------
// fifo input stage
// takes the input stream, applies bit errors, writes memory
// ------------------------------
`include "dram_fifo_cfg.svh"

module dram_fifo_ingress (
    input  logic                      ddr3_axi_clk,
    input  logic                      i_reset,
    input  dram_fifo_pkg::df_data_t   i_tdata,
    input  logic                      i_tlast,
    input  logic                      i_tvalid,
    output logic                      o_tready,
    input  dram_fifo_pkg::df_data_t   i_forced_bit_err,
    input  logic                      i_calib_done,
    input  dram_fifo_pkg::df_ptr_t    i_rd_ptr,      // retire pointer from egress
    mem_wr_if.wr                      wr,
    output logic                      o_pkt_in_stb
);

    dram_fifo_pkg::df_word_t  word_q;                // accepted word, mask applied
    logic                     stb_q;                 // word_q waits for its write
    dram_fifo_pkg::df_ptr_t   wr_ptr_q;              // next address to write
    dram_fifo_pkg::df_level_t fill;                  // words owned by the fifo
    logic                     full;
    logic                     accept;

    // the word in word_q already counts toward fill
    assign fill   = wr_ptr_q - i_rd_ptr + {{`DF_ADDR_W{1'b0}}, stb_q};
    assign full   = (fill == dram_fifo_pkg::df_level_t'(`DF_DEPTH));
    assign o_tready = i_calib_done & ~full;          // closed until memory is cleared
    assign accept = i_tvalid & o_tready;

    assign o_pkt_in_stb = accept & i_tlast;          // one pulse per packet

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge ddr3_axi_clk) begin
        if (i_reset) begin
            stb_q    <= 1'b0;
            wr_ptr_q <= '0;
        end else begin
            stb_q <= accept;                         // write one cycle after accept
            if (stb_q) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;         // advances on the write edge
            end
        end
    end

    // error mask sampled with the data, tlast left alone
    always_ff @(posedge ddr3_axi_clk) begin
        if (accept) begin
            word_q.data <= i_tdata ^ i_forced_bit_err;
            word_q.last <= i_tlast;
        end
    end

    assign wr.wr_stb  = stb_q;
    assign wr.wr_addr = wr_ptr_q[`DF_ADDR_W-1:0];
    assign wr.wr_data = word_q;
    assign wr.wr_ptr  = wr_ptr_q;                    // egress sees it after the write lands

endmodule

/* logic/dram_fifo_mem.sv */
// ------------------------------
// fifo backing memory
// clears itself after reset, then one write and one read port
// ------------------------------
`include "dram_fifo_cfg.svh"

module dram_fifo_mem #(
    parameter type payload_t = logic
) (
    input  logic  ddr3_axi_clk,
    input  logic  i_reset,
    mem_wr_if.sink wr,
    mem_rd_if.src  rd,
    output logic  o_init_calib_complete
);

    payload_t                 mem_q [`DF_DEPTH];
    dram_fifo_pkg::df_ptr_t   clr_cnt_q;             // top bit set once sweep is done
    logic                     clearing;
    logic                     we;
    dram_fifo_pkg::df_addr_t  waddr;
    payload_t                 wdata;
    logic                     calib_q;
    logic                     rd_valid_q;
    payload_t                 rd_data_q;

    assign clearing = ~clr_cnt_q[`DF_ADDR_W];
    assign we       = clearing | wr.wr_stb;          // stream is held off while clearing
    assign waddr    = clearing ? clr_cnt_q[`DF_ADDR_W-1:0] : wr.wr_addr;
    assign wdata    = clearing ? '0 : wr.wr_data;

    // ------------------------------
    // clear sweep and calibration flag
    // ------------------------------
    always_ff @(posedge ddr3_axi_clk) begin
        if (i_reset) begin
            clr_cnt_q <= '0;
            calib_q   <= 1'b0;
        end else begin
            if (clearing) begin
                clr_cnt_q <= clr_cnt_q + 1'b1;       // one address per cycle
            end
            calib_q <= clr_cnt_q[`DF_ADDR_W];        // one cycle after the last clear write
        end
    end

    // array write, sweep or stream
    always_ff @(posedge ddr3_axi_clk) begin
        if (we) begin
            mem_q[waddr] <= wdata;
        end
    end

    // ------------------------------
    // registered read
    // ------------------------------
    always_ff @(posedge ddr3_axi_clk) begin
        if (i_reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd.rd_stb;
        end
    end

    always_ff @(posedge ddr3_axi_clk) begin
        rd_data_q <= mem_q[rd.rd_addr];              // old data on same-address write
    end

    assign rd.rd_valid           = rd_valid_q;
    assign rd.rd_data            = rd_data_q;
    assign o_init_calib_complete = calib_q;

endmodule

/* logic/dram_fifo_pkg.sv */
// ------------------------------
// dram fifo shared types
// stream word, memory word, pointers, readback select
// ------------------------------
`include "dram_fifo_cfg.svh"

package dram_fifo_pkg;

    typedef logic [`DF_DATA_W-1:0] df_data_t;      // one stream beat

    typedef struct packed {
        logic     last;                            // end of packet
        df_data_t data;
    } df_word_t;                                   // what sits in memory

    typedef logic [`DF_ADDR_W-1:0] df_addr_t;      // memory address
    typedef logic [`DF_ADDR_W:0]   df_ptr_t;       // address plus wrap bit
    typedef logic [`DF_ADDR_W:0]   df_level_t;     // 0 .. depth

    // what o_rb_data shows
    typedef enum logic [1:0] {
        RB_LEVEL    = 2'd0,                        // words held
        RB_PKTS_IN  = 2'd1,                        // packets accepted
        RB_PKTS_OUT = 2'd2                         // packets delivered
    } df_rb_sel_t;

endpackage

/* logic/dram_fifo_settings.sv */
// ------------------------------
// settings register and readback
// select register, packet counters, readback mux
// ------------------------------
`include "dram_fifo_cfg.svh"

module dram_fifo_settings (
    input  logic                      ddr3_axi_clk,
    input  logic                      i_reset,
    input  logic                      i_set_stb,
    input  logic [7:0]                i_set_addr,
    input  logic [31:0]               i_set_data,
    output logic [31:0]               o_rb_data,
    input  dram_fifo_pkg::df_level_t  i_level,
    input  logic                      i_pkt_in_stb,
    input  logic                      i_pkt_out_stb
);

    dram_fifo_pkg::df_rb_sel_t sel_q;
    logic [31:0]               pkts_in_q;            // last words accepted
    logic [31:0]               pkts_out_q;           // last words delivered
    logic [31:0]               rb_next;

    // ------------------------------
    // select register and counters
    // ------------------------------
    always_ff @(posedge ddr3_axi_clk) begin
        if (i_reset) begin
            sel_q      <= dram_fifo_pkg::RB_LEVEL;
            pkts_in_q  <= 32'd0;
            pkts_out_q <= 32'd0;
        end else begin
            if (i_set_stb && (i_set_addr == `DF_SR_BASE)) begin
                sel_q <= dram_fifo_pkg::df_rb_sel_t'(i_set_data[1:0]);
            end
            if (i_pkt_in_stb) begin
                pkts_in_q <= pkts_in_q + 32'd1;      // wraps, no saturation
            end
            if (i_pkt_out_stb) begin
                pkts_out_q <= pkts_out_q + 32'd1;
            end
        end
    end

    // readback mux, unused code reads zero
    always_comb begin
        case (sel_q)
            dram_fifo_pkg::RB_LEVEL:    rb_next = {{(31-`DF_ADDR_W){1'b0}}, i_level};
            dram_fifo_pkg::RB_PKTS_IN:  rb_next = pkts_in_q;
            dram_fifo_pkg::RB_PKTS_OUT: rb_next = pkts_out_q;
            default:                    rb_next = 32'd0;
        endcase
    end

    always_ff @(posedge ddr3_axi_clk) begin
        o_rb_data <= rb_next;                        // one cycle behind the select
    end

endmodule

/* logic/dram_fifo_top.sv */
// ------------------------------
// memory backed packet fifo
// 64 bit stream in, 64 bit stream out, settings readback
// ------------------------------
module dram_fifo_top (
    input  logic                      ddr3_axi_clk,
    input  logic                      i_reset,
    input  dram_fifo_pkg::df_data_t   i_tdata,
    input  logic                      i_tlast,
    input  logic                      i_tvalid,
    output logic                      o_tready,
    output dram_fifo_pkg::df_data_t   o_tdata,
    output logic                      o_tlast,
    output logic                      o_tvalid,
    input  logic                      i_tready,
    input  logic                      i_set_stb,
    input  logic [7:0]                i_set_addr,
    input  logic [31:0]               i_set_data,
    output logic [31:0]               o_rb_data,
    input  dram_fifo_pkg::df_data_t   i_forced_bit_err,
    output logic                      o_init_calib_complete
);

    dram_fifo_pkg::df_ptr_t   rd_ptr;                // retire pointer back to ingress
    dram_fifo_pkg::df_level_t level;
    logic                     pkt_in_stb;
    logic                     pkt_out_stb;

    mem_wr_if #(.payload_t(dram_fifo_pkg::df_word_t)) u_wr_if ();
    mem_rd_if #(.payload_t(dram_fifo_pkg::df_word_t)) u_rd_if ();

    // ------------------------------
    // write path
    // ------------------------------
    dram_fifo_ingress u_ingress (
        .ddr3_axi_clk     (ddr3_axi_clk),
        .i_reset          (i_reset),
        .i_tdata          (i_tdata),
        .i_tlast          (i_tlast),
        .i_tvalid         (i_tvalid),
        .o_tready         (o_tready),
        .i_forced_bit_err (i_forced_bit_err),
        .i_calib_done     (o_init_calib_complete),   // stream waits for the clear sweep
        .i_rd_ptr         (rd_ptr),
        .wr               (u_wr_if.wr),
        .o_pkt_in_stb     (pkt_in_stb)
    );

    dram_fifo_mem #(.payload_t(dram_fifo_pkg::df_word_t)) u_mem (
        .ddr3_axi_clk          (ddr3_axi_clk),
        .i_reset               (i_reset),
        .wr                    (u_wr_if.sink),
        .rd                    (u_rd_if.src),
        .o_init_calib_complete (o_init_calib_complete)
    );

    // ------------------------------
    // read path and settings
    // ------------------------------
    dram_fifo_egress u_egress (
        .ddr3_axi_clk  (ddr3_axi_clk),
        .i_reset       (i_reset),
        .wr_mon        (u_wr_if.mon),
        .rd            (u_rd_if.rd),
        .o_rd_ptr      (rd_ptr),
        .o_tdata       (o_tdata),
        .o_tlast       (o_tlast),
        .o_tvalid      (o_tvalid),
        .i_tready      (i_tready),
        .o_level       (level),
        .o_pkt_out_stb (pkt_out_stb)
    );

    dram_fifo_settings u_settings (
        .ddr3_axi_clk  (ddr3_axi_clk),
        .i_reset       (i_reset),
        .i_set_stb     (i_set_stb),
        .i_set_addr    (i_set_addr),
        .i_set_data    (i_set_data),
        .o_rb_data     (o_rb_data),
        .i_level       (level),
        .i_pkt_in_stb  (pkt_in_stb),
        .i_pkt_out_stb (pkt_out_stb)
    );

endmodule

/* src.f */
+incdir+logic
logic/dram_fifo_pkg.sv
logic/dram_fifo_if.sv
logic/dram_fifo_ingress.sv
logic/dram_fifo_mem.sv
logic/dram_fifo_egress.sv
logic/dram_fifo_settings.sv
logic/dram_fifo_top.sv
bench/tb_dram_fifo.sv
